//--- Makefile
VERILATOR ?= verilator
TOP       ?= ethRxTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/ethRxPkg.sv
`default_nettype none

package ethRxPkg;

  // One-hot receive state
  typedef enum logic [4:0] {
    RX_IDLE     = 5'b00001,
    RX_PREAMBLE = 5'b00010,
    RX_SFD      = 5'b00100,
    RX_DATA0    = 5'b01000,
    RX_DATA1    = 5'b10000
  } rxStateT;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } rxByteT;

  typedef struct packed {
    logic [15:0] byteCount;
    logic        crcError;
    logic        mrxErr;
    logic        invalidSymbol;
    logic        lateCollision;
    logic        shortFrame;
    logic        tooBig;
    logic        dribbleNibble;
    logic        overrun;
  } rxStatusT;

  typedef struct packed {
    logic [15:0] minFl;
    logic [15:0] maxFl;
    logic        hugeEn;
    logic        recSmall;
    logic        fullDuplex;
    logic [5:0]  collValid;
  } rxConfigT;

endpackage

`default_nettype wire

//--- common/eth_defs.svh
`ifndef ETH_DEFS_SVH
`define ETH_DEFS_SVH

// Default frame length limits in bytes
`define ETH_MIN_FL 16'd64
`define ETH_MAX_FL 16'd1518

// Output buffer depths
`define ETH_DATA_DEPTH 16
`define ETH_STAT_DEPTH 4

// Credits per channel granted by the consumer after reset
`define ETH_CREDITS 4

// CRC register contents after a good frame with its FCS
`define ETH_CRC_RESIDUE 32'hC704_DD7B

`endif

//--- ethRx/ethMacStatus.sv
`timescale 1ns/1ps
`default_nettype none

module ethMacStatus (
  input  wire logic               MRxClk,
  input  wire logic               Reset,
  input  wire logic [3:0]         MRxD,
  input  wire logic               MRxDV,
  input  wire logic               MRxErr,
  input  wire logic               Collision,
  input  wire ethRxPkg::rxConfigT cfg,
  input  wire ethRxPkg::rxStateT  rxState,
  input  wire logic [15:0]        rxByteCnt,
  input  wire logic               byteCntEq0,
  input  wire logic               byteCntMaxFrame,
  input  wire logic               crcError,
  input  wire logic               dataFull,
  input  wire logic               byteValid,
  output logic                    loadRxStatus,
  output ethRxPkg::rxStatusT      status
);

  logic        inData0;
  logic        inData1;
  logic        inFrame;
  logic        takeSample;
  logic        setInvalidSymbol;
  logic        latchedCrcError;
  logic        latchedMRxErr;
  logic        invalidSymbol;
  logic        lateCollision;
  logic        colWindow;
  logic        shortFrame;
  logic        tooBig;
  logic        dribbleNibble;
  logic        overrun;
  logic [15:0] sampledCnt;

  assign inData0 = rxState == ethRxPkg::RX_DATA0;
  assign inData1 = rxState == ethRxPkg::RX_DATA1;
  assign inFrame = (rxState == ethRxPkg::RX_PREAMBLE) | (rxState == ethRxPkg::RX_SFD) |
                   inData0 | inData1;

  assign takeSample = (inData0 | inData1) & ~MRxDV | inData0 & byteCntMaxFrame;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      loadRxStatus <= 1'b0;
    else
      loadRxStatus <= takeSample;
  end

  // CRC result is also taken when a dribble nibble ends the frame
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      latchedCrcError <= 1'b0;
    else if (rxState == ethRxPkg::RX_SFD)
      latchedCrcError <= 1'b0;
    else if (inData0 & ~byteCntEq0 | inData1 & ~MRxDV)
      latchedCrcError <= crcError;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      latchedMRxErr <= 1'b0;
    else if (MRxErr & MRxDV & inFrame)
      latchedMRxErr <= 1'b1;
    else if (loadRxStatus)
      latchedMRxErr <= 1'b0;
  end

  assign setInvalidSymbol = MRxDV & MRxErr & (MRxD == 4'he);

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      invalidSymbol <= 1'b0;
    else if (loadRxStatus & ~setInvalidSymbol)
      invalidSymbol <= 1'b0;
    else if (setInvalidSymbol)
      invalidSymbol <= 1'b1;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      lateCollision <= 1'b0;
    else if (loadRxStatus)
      lateCollision <= 1'b0;
    else if (Collision & ~cfg.fullDuplex & (~colWindow | cfg.recSmall))
      lateCollision <= 1'b1;
  end

  // Window closes once collValid bytes passed without a collision
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      colWindow <= 1'b1;
    else if (~Collision & (rxByteCnt[5:0] == cfg.collValid) & inData1)
      colWindow <= 1'b0;
    else if (rxState == ethRxPkg::RX_IDLE)
      colWindow <= 1'b1;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      shortFrame <= 1'b0;
      tooBig     <= 1'b0;
    end
    else if (loadRxStatus)
    begin
      shortFrame <= 1'b0;
      tooBig     <= 1'b0;
    end
    else if (takeSample)
    begin
      shortFrame <= rxByteCnt < cfg.minFl;
      tooBig     <= ~cfg.hugeEn & (rxByteCnt > cfg.maxFl);
    end
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      dribbleNibble <= 1'b0;
      overrun       <= 1'b0;
    end
    else if (rxState == ethRxPkg::RX_SFD)
    begin
      dribbleNibble <= 1'b0;
      overrun       <= 1'b0;
    end
    else
    begin
      if (~MRxDV & inData1)
        dribbleNibble <= 1'b1;
      if (byteValid & dataFull)
        overrun <= 1'b1;
    end
  end

  always_ff @(posedge MRxClk)
  begin
    if (takeSample)
      sampledCnt <= rxByteCnt;
  end

  // Last byte is pushed in the load cycle itself
  always_comb
  begin
    status.byteCount     = sampledCnt;
    status.crcError      = latchedCrcError;
    status.mrxErr        = latchedMRxErr;
    status.invalidSymbol = invalidSymbol;
    status.lateCollision = lateCollision;
    status.shortFrame    = shortFrame;
    status.tooBig        = tooBig;
    status.dribbleNibble = dribbleNibble;
    status.overrun       = overrun | byteValid & dataFull;
  end

  loadNotBackToBack: assert property (@(posedge MRxClk) disable iff (Reset)
    loadRxStatus |=> !loadRxStatus);

endmodule

`default_nettype wire

//--- ethRx/ethRxCrc.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module ethRxCrc (
  input  wire logic              MRxClk,
  input  wire logic              Reset,
  input  wire ethRxPkg::rxStateT rxState,
  input  wire logic [3:0]        MRxD,
  output logic                   crcError
);

  logic [31:0] crc;

  // Bit-serial CRC-32 taking nibble bit 0 first
  function automatic logic [31:0] crcNext(input logic [31:0] crcIn, input logic [3:0] d);
    logic [31:0] c;
    logic        fb;
    c = crcIn;
    for (int i = 0; i < 4; i++)
    begin
      fb = c[31] ^ d[i];
      c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
    end
    return c;
  endfunction

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      crc <= 32'hFFFF_FFFF;
    else
    begin
      case (rxState)
        // Preset and first data nibble together
        ethRxPkg::RX_SFD:
          crc <= crcNext(32'hFFFF_FFFF, MRxD);
        ethRxPkg::RX_DATA0,
        ethRxPkg::RX_DATA1:
          crc <= crcNext(crc, MRxD);
        default:
          crc <= crc;
      endcase
    end
  end

  assign crcError = crc != `ETH_CRC_RESIDUE;

endmodule

`default_nettype wire

//--- ethRx/ethRxStateMachine.sv
`timescale 1ns/1ps
`default_nettype none

module ethRxStateMachine (
  input  wire logic              MRxClk,
  input  wire logic              Reset,
  input  wire logic [3:0]        MRxD,
  input  wire logic              MRxDV,
  input  wire ethRxPkg::rxConfigT cfg,
  output ethRxPkg::rxStateT      rxState,
  output logic [15:0]            rxByteCnt,
  output logic                   byteCntEq0,
  output logic                   byteCntMaxFrame,
  output ethRxPkg::rxByteT       byteOut,
  output logic                   byteValid
);

  logic       waitDvLow;
  logic [3:0] lowNibble;
  logic [7:0] heldByte;
  logic       heldValid;
  logic       byteDone;
  logic       frameEnd;
  logic       truncate;

  assign byteCntEq0      = rxByteCnt == 16'd0;
  assign byteCntMaxFrame = ~cfg.hugeEn & (rxByteCnt == cfg.maxFl + 16'd1);

  assign byteDone = (rxState == ethRxPkg::RX_DATA1) & MRxDV;
  assign truncate = (rxState == ethRxPkg::RX_DATA0) & MRxDV & byteCntMaxFrame;
  assign frameEnd = ((rxState == ethRxPkg::RX_DATA0) | (rxState == ethRxPkg::RX_DATA1)) &
                    ~MRxDV | truncate;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      rxState   <= ethRxPkg::RX_IDLE;
      waitDvLow <= 1'b0;
    end
    else
    begin
      case (rxState)
        ethRxPkg::RX_IDLE:
        begin
          if (~MRxDV)
            waitDvLow <= 1'b0;
          else if (~waitDvLow)
            rxState <= ethRxPkg::RX_PREAMBLE;
        end
        ethRxPkg::RX_PREAMBLE:
        begin
          if (~MRxDV)
            rxState <= ethRxPkg::RX_IDLE;
          else if (MRxD == 4'hd)
            rxState <= ethRxPkg::RX_SFD;
        end
        // First low nibble of the frame arrives here
        ethRxPkg::RX_SFD:
          rxState <= MRxDV ? ethRxPkg::RX_DATA1 : ethRxPkg::RX_IDLE;
        ethRxPkg::RX_DATA1:
          rxState <= MRxDV ? ethRxPkg::RX_DATA0 : ethRxPkg::RX_IDLE;
        ethRxPkg::RX_DATA0:
        begin
          if (~MRxDV)
            rxState <= ethRxPkg::RX_IDLE;
          else if (byteCntMaxFrame)
          begin
            rxState   <= ethRxPkg::RX_IDLE;
            waitDvLow <= 1'b1;
          end
          else
            rxState <= ethRxPkg::RX_DATA1;
        end
        default:
          rxState <= ethRxPkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      rxByteCnt <= 16'd0;
    else if ((rxState == ethRxPkg::RX_IDLE) | (rxState == ethRxPkg::RX_PREAMBLE))
      rxByteCnt <= 16'd0;
    else if (byteDone)
      rxByteCnt <= rxByteCnt + 16'd1;
  end

  always_ff @(posedge MRxClk)
  begin
    if (MRxDV & ((rxState == ethRxPkg::RX_SFD) | (rxState == ethRxPkg::RX_DATA0)))
      lowNibble <= MRxD;
    if (byteDone)
      heldByte <= {MRxD, lowNibble};
    if ((byteDone | frameEnd) & heldValid)
      byteOut <= '{data: heldByte, last: frameEnd};
  end

  // Held byte goes out when the next one completes or the frame ends
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      heldValid <= 1'b0;
      byteValid <= 1'b0;
    end
    else
    begin
      byteValid <= (byteDone | frameEnd) & heldValid;
      if (byteDone)
        heldValid <= 1'b1;
      else if (frameEnd)
        heldValid <= 1'b0;
    end
  end

  stateOneHot: assert property (@(posedge MRxClk) disable iff (Reset) $onehot(rxState));

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/ethRxPkg.sv
ethRx/ethRxStateMachine.sv
ethRx/ethRxCrc.sv
ethRx/ethMacStatus.sv
verilog/ethCreditFifo.sv
verilog/ethRxTop.sv
tb/ethRxTb.sv

//--- tb/ethRxTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module ethRxTb;

  localparam int numFrames   = 48;
  localparam int overrunKeep = `ETH_CREDITS + `ETH_DATA_DEPTH;
  localparam int minFlBytes  = `ETH_MIN_FL;
  localparam int maxFlBytes  = `ETH_MAX_FL;

  logic               MRxClk = 1'b0;
  logic               Reset = 1'b1;
  logic [3:0]         MRxD = 4'h0;
  logic               MRxDV = 1'b0;
  logic               MRxErr = 1'b0;
  logic               Collision = 1'b0;
  ethRxPkg::rxConfigT cfg = '0;
  logic               dataCreditReturn = 1'b0;
  logic               statusCreditReturn = 1'b0;
  logic               dataValid;
  ethRxPkg::rxByteT   dataOut;
  logic               statusValid;
  ethRxPkg::rxStatusT statusOut;

  string variantName [0:10] = '{"goodFrame", "badFcs", "dribbleNibble", "invalidSymbol",
    "mrxErr", "earlyCollision", "lateCollision", "shortFrame", "tooBig", "hugeFrame",
    "overrun"};

  int                 frameVariant [numFrames];
  int                 frameLen [numFrames];
  int                 frameGap [numFrames];
  logic [7:0]         frame [$];
  ethRxPkg::rxByteT   expData [$];
  string              expDataName [$];
  ethRxPkg::rxStatusT expStatus [$];
  string              expStatusName [$];
  int                 dataDue [$];
  int                 statusDue [$];
  int                 cycle = 0;
  int                 dataReceived = 0;
  int                 dataReturned = 0;
  int                 returnedLag1 = 0;
  int                 returnedLag2 = 0;
  int                 mismatchCount = 0;
  int                 otherCount = 0;
  logic               holdData = 1'b0;
  longint             watchdogNs = 0;

  ethRxTop dut_i (
    .MRxClk, .Reset, .MRxD, .MRxDV, .MRxErr, .Collision, .cfg,
    .dataCreditReturn, .statusCreditReturn,
    .dataValid, .dataOut, .statusValid, .statusOut
  );

  always #2 MRxClk = ~MRxClk;

  task automatic compareValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual)
    begin
      mismatchCount++;
      $display("ERROR %s: expected %h, actual %h (at %0t)", testName, expected, actual, $time);
    end
  endtask

  // Reflected CRC-32 of the first n bytes as sent in the FCS
  function automatic logic [31:0] fcsOf(input int n);
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    for (int i = 0; i < n; i++)
    begin
      crc = crc ^ {24'h0, frame[i]};
      for (int b = 0; b < 8; b++)
        crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
    end
    return ~crc;
  endfunction

  task automatic sendFrame(input int f);
    ethRxPkg::rxConfigT nextCfg;
    ethRxPkg::rxStatusT st;
    string              name;
    logic [31:0]        fcs;
    logic [3:0]         nib;
    int                 v;
    int                 len;
    int                 kept;
    int                 errByte;
    int                 collByte;
    int                 b;
    v = frameVariant[f];
    len = frameLen[f];
    name = $sformatf("%s_%0d", variantName[v], f);
    // Overrun needs an empty byte buffer and all credits back
    if (v == 10)
    begin
      while (expData.size() != 0 || dataDue.size() != 0)
        @(posedge MRxClk);
      repeat (3) @(posedge MRxClk);
      holdData <= 1'b1;
    end
    nextCfg.minFl = 16'(minFlBytes);
    nextCfg.maxFl = 16'(maxFlBytes);
    nextCfg.hugeEn = (v == 9) ? 1'b1 : (v == 8) ? 1'b0 : 1'($urandom_range(1, 0));
    nextCfg.recSmall = 1'($urandom_range(1, 0));
    nextCfg.fullDuplex = 1'($urandom_range(1, 0));
    nextCfg.collValid = 6'($urandom_range(40, 3));
    errByte = $urandom_range(len - 5, 2);
    collByte = (v == 5) ? 2 : int'(nextCfg.collValid) + 4;

    frame.delete();
    for (int i = 0; i < len - 4; i++)
      frame.push_back(8'($urandom));
    if (v == 3)
      frame[errByte] = {frame[errByte][7:4], 4'he};
    if (v == 4)
      frame[errByte] = {frame[errByte][7:4], 4'h3};
    fcs = fcsOf(len - 4);
    if (v == 1)
      fcs = fcs ^ (32'h1 << $urandom_range(31, 0));
    for (int k = 0; k < 4; k++)
      frame.push_back(fcs[8*k +: 8]);

    // Reference model of the delivered bytes and the status record
    kept = (!nextCfg.hugeEn && len > maxFlBytes + 1) ? maxFlBytes + 1 : len;
    for (int i = 0; i < kept; i++)
    begin
      if (v != 10 || i < overrunKeep)
      begin
        expData.push_back(ethRxPkg::rxByteT'{data: frame[i], last: (i == kept - 1)});
        expDataName.push_back(name);
      end
    end
    st = '0;
    st.byteCount = 16'(kept);
    st.crcError = (v == 2) || (fcsOf(kept - 4) !=
                  {frame[kept-1], frame[kept-2], frame[kept-3], frame[kept-4]});
    st.mrxErr = (v == 3) || (v == 4);
    st.invalidSymbol = v == 3;
    st.lateCollision = (v == 5 || v == 6) && !nextCfg.fullDuplex && (v == 6 || nextCfg.recSmall);
    st.shortFrame = kept < minFlBytes;
    st.tooBig = !nextCfg.hugeEn && kept > maxFlBytes;
    st.dribbleNibble = v == 2;
    st.overrun = v == 10;
    expStatus.push_back(st);
    expStatusName.push_back(name);

    @(posedge MRxClk);
    cfg <= nextCfg;
    // Preamble and SFD, then data low nibble first, then the dribble nibble
    for (int n = 0; n < 2 * (len + 8) + int'(v == 2); n++)
    begin
      @(posedge MRxClk);
      b = n / 2 - 8;
      if (n < 16)
        nib = (n == 15) ? 4'hd : 4'h5;
      else if (b < len)
        nib = (n % 2 == 1) ? frame[b][7:4] : frame[b][3:0];
      else
        nib = 4'($urandom);
      MRxD <= nib;
      MRxDV <= 1'b1;
      MRxErr <= (v == 3 || v == 4) && n == 16 + 2 * errByte;
      Collision <= (v == 5 || v == 6) && n >= 16 && b == collByte;
    end
    @(posedge MRxClk);
    MRxD <= 4'h0;
    MRxDV <= 1'b0;
    MRxErr <= 1'b0;
    Collision <= 1'b0;
    repeat (frameGap[f]) @(posedge MRxClk);
    if (v == 10)
    begin
      repeat (4) @(posedge MRxClk);
      holdData <= 1'b0;
    end
  endtask

  // Consumer with random credit return delay
  always @(posedge MRxClk)
  begin
    int due;
    int baseReturned;
    cycle++;
    baseReturned = returnedLag2;
    returnedLag2 = returnedLag1;
    returnedLag1 = dataReturned;
    if (!Reset)
    begin
      if (dataValid)
      begin
        if (dataReceived - baseReturned >= `ETH_CREDITS)
        begin
          otherCount++;
          $display("Data valid without an available credit at %0t", $time);
        end
        dataReceived++;
        if (expData.size() == 0)
        begin
          otherCount++;
          $display("Unexpected data byte %h at %0t", dataOut, $time);
        end
        else
          compareValue(expDataName.pop_front(), 32'(expData.pop_front()), 32'(dataOut));
        due = cycle + int'($urandom_range(3, 0));
        if (dataDue.size() > 0 && due <= dataDue[$])
          due = dataDue[$] + 1;
        dataDue.push_back(due);
      end
      if (statusValid)
      begin
        if (expStatus.size() == 0)
        begin
          otherCount++;
          $display("Unexpected status record %h at %0t", statusOut, $time);
        end
        else
          compareValue(expStatusName.pop_front(), 32'(expStatus.pop_front()), 32'(statusOut));
        due = cycle + int'($urandom_range(3, 0));
        if (statusDue.size() > 0 && due <= statusDue[$])
          due = statusDue[$] + 1;
        statusDue.push_back(due);
      end
      if (!holdData && dataDue.size() > 0 && dataDue[0] <= cycle)
      begin
        void'(dataDue.pop_front());
        dataCreditReturn <= 1'b1;
        dataReturned++;
      end
      else
        dataCreditReturn <= 1'b0;
      if (statusDue.size() > 0 && statusDue[0] <= cycle)
      begin
        void'(statusDue.pop_front());
        statusCreditReturn <= 1'b1;
      end
      else
        statusCreditReturn <= 1'b0;
    end
  end

  initial
  begin
    longint total;
    void'($urandom(32'h90a7_baae));
    total = 0;
    for (int f = 0; f < numFrames; f++)
    begin
      // Every variant once, then random ones
      if (f <= 10)
        frameVariant[f] = f;
      else
        frameVariant[f] = $urandom_range(10, 0);
      if (frameVariant[f] == 7)
        frameLen[f] = $urandom_range(minFlBytes - 1, 6);
      else if (frameVariant[f] == 8 || frameVariant[f] == 9)
        frameLen[f] = $urandom_range(maxFlBytes + 20, maxFlBytes + 1);
      else
        frameLen[f] = $urandom_range(200, minFlBytes);
      frameGap[f] = $urandom_range(12, 2);
      total += 2 * (frameLen[f] + 8) + 2 + frameGap[f];
    end
    watchdogNs = (total + 100 * numFrames + 500) * 4 * 2;

    repeat (5) @(posedge MRxClk);
    Reset <= 1'b0;
    repeat (3) @(posedge MRxClk);
    for (int f = 0; f < numFrames; f++)
      sendFrame(f);
    while (expData.size() != 0 || expStatus.size() != 0)
      @(posedge MRxClk);
    repeat (20) @(posedge MRxClk);
    $display("Done: %0d value mismatches, %0d other errors", mismatchCount, otherCount);
    if (mismatchCount + otherCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    while (watchdogNs == 0)
      @(posedge MRxClk);
    #(watchdogNs);
    $display("Timeout: %0d bytes and %0d status records never arrived",
             expData.size(), expStatus.size());
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ethCreditFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module ethCreditFifo #(
  parameter type itemT = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  wire logic MRxClk,
  input  wire logic Reset,
  input  wire logic push,
  input  wire itemT pushItem,
  input  wire logic creditReturn,
  output logic      full,
  output logic      outValid,
  output itemT      outItem
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(`ETH_CREDITS + 1);

  itemT          mem [DEPTH];
  logic [PW-1:0] wrPtr;
  logic [PW-1:0] rdPtr;
  logic [PW:0]   count;
  logic [CW-1:0] credits;
  logic          send;

  assign full = count == (PW+1)'(DEPTH);

  // Empty buffer lets a pushed item straight through
  assign send = (credits != '0) & ((count != '0) | push);

  always_ff @(posedge MRxClk)
  begin
    if (push)
      mem[wrPtr] <= pushItem;
    if (send)
      outItem <= (count != '0) ? mem[rdPtr] : pushItem;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      credits  <= CW'(`ETH_CREDITS);
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= send;
      if (push)
        wrPtr <= (wrPtr == PW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (send)
        rdPtr <= (rdPtr == PW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      count   <= count + (PW+1)'(push) - (PW+1)'(send);
      credits <= credits + CW'(creditReturn) - CW'(send);
    end
  end

  creditBound: assert property (@(posedge MRxClk) disable iff (Reset)
    credits <= CW'(`ETH_CREDITS));

endmodule

`default_nettype wire

//--- verilog/ethRxTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module ethRxTop (
  input  wire logic               MRxClk,
  input  wire logic               Reset,
  input  wire logic [3:0]         MRxD,
  input  wire logic               MRxDV,
  input  wire logic               MRxErr,
  input  wire logic               Collision,
  input  wire ethRxPkg::rxConfigT cfg,
  input  wire logic               dataCreditReturn,
  input  wire logic               statusCreditReturn,
  output logic                    dataValid,
  output ethRxPkg::rxByteT        dataOut,
  output logic                    statusValid,
  output ethRxPkg::rxStatusT      statusOut
);

  ethRxPkg::rxStateT  rxState;
  logic [15:0]        rxByteCnt;
  logic               byteCntEq0;
  logic               byteCntMaxFrame;
  ethRxPkg::rxByteT   byteOut;
  logic               byteValid;
  logic               crcError;
  logic               dataFull;
  logic               statusFull;
  logic               loadRxStatus;
  ethRxPkg::rxStatusT status;

  ethRxStateMachine stateMachine_i (
    .MRxClk, .Reset, .MRxD, .MRxDV, .cfg,
    .rxState, .rxByteCnt, .byteCntEq0, .byteCntMaxFrame,
    .byteOut, .byteValid
  );

  ethRxCrc crc_i (
    .MRxClk, .Reset, .rxState, .MRxD, .crcError
  );

  ethMacStatus status_i (
    .MRxClk, .Reset, .MRxD, .MRxDV, .MRxErr, .Collision, .cfg,
    .rxState, .rxByteCnt, .byteCntEq0, .byteCntMaxFrame, .crcError,
    .dataFull, .byteValid, .loadRxStatus, .status
  );

  // Bytes and records arriving at a full buffer are dropped
  ethCreditFifo #(.itemT(ethRxPkg::rxByteT), .DEPTH(`ETH_DATA_DEPTH)) dataFifo_i (
    .MRxClk, .Reset,
    .push(byteValid & ~dataFull), .pushItem(byteOut),
    .creditReturn(dataCreditReturn), .full(dataFull),
    .outValid(dataValid), .outItem(dataOut)
  );

  ethCreditFifo #(.itemT(ethRxPkg::rxStatusT), .DEPTH(`ETH_STAT_DEPTH)) statusFifo_i (
    .MRxClk, .Reset,
    .push(loadRxStatus & ~statusFull), .pushItem(status),
    .creditReturn(statusCreditReturn), .full(statusFull),
    .outValid(statusValid), .outItem(statusOut)
  );

endmodule

`default_nettype wire
